// File: cam_capture_config.svh
`ifndef CAM_CAPTURE_CONFIG_SVH
`define CAM_CAPTURE_CONFIG_SVH

////////////////////////////////////////
// frame geometry
////////////////////////////////////////

// kept small so a whole frame simulates in a few thousand cycles
// a real sensor frame would be 640 by 480 with wider counters

// active pixels in one href-high line
`define CAM_H_PIXELS 16

// active lines between the vsync falling and rising edges
`define CAM_V_LINES 8

////////////////////////////////////////
// widths
////////////////////////////////////////

// column and line counters
`define CAM_COORD_W 8

// frame store address, must cover CAM_H_PIXELS * CAM_V_LINES
`define CAM_ADDR_W 7

`endif

// File: cam_capture_pkg.sv
`default_nettype none

`include "cam_capture_config.svh"

package cam_capture_pkg;

    ////////////////////////////////////////
    // data widths
    ////////////////////////////////////////

    typedef logic [7:0]  byte_t;     // one byte off the sensor bus
    typedef logic [15:0] pixel565_t; // r[15:11] g[10:5] b[4:0]
    typedef logic [23:0] rgb888_t;   // r[23:16] g[15:8] b[7:0]

    // column or line number
    typedef logic [`CAM_COORD_W-1:0] coord_t;

    // linear frame store address
    typedef logic [`CAM_ADDR_W-1:0] addr_t;

    ////////////////////////////////////////
    // pixel stream between pairing and store
    ////////////////////////////////////////

    typedef struct packed {
        logic      valid;  // one cycle strobe per pixel
        pixel565_t pix;
        coord_t    hcount; // column within the line
        coord_t    vcount; // line within the frame
    } cam_pixel_s;

    ////////////////////////////////////////
    // frame sync FSM
    ////////////////////////////////////////

    typedef enum logic [1:0] {
        SYNC_IDLE    = 2'd0, // waiting for a start edge
        SYNC_ARMED   = 2'd1, // waiting for vsync to fall
        SYNC_CAPTURE = 2'd2  // frame active until vsync rises
    } sync_state_e;

endpackage

`default_nettype wire

// File: cam_frame_sync.sv
`timescale 1ns/100ps
`default_nettype none

module cam_frame_sync
    import cam_capture_pkg::*;
(
    input  logic camera_clk,
    input  logic rst,
    input  logic start,       // level where only the rising edge counts
    input  logic cam_vsync,   // high in vertical blanking
    output logic busy,
    output logic done,
    output logic capture_en,
    output logic frame_start
);

    sync_state_e state;

    logic start_q;    // previous start sample
    logic vsync_q;    // previous vsync sample
    logic start_rise;
    logic vsync_fall;
    logic vsync_rise;

    ////////////////////////////////////////
    // edge detect
    ////////////////////////////////////////

    assign start_rise = start & ~start_q;
    assign vsync_fall = ~cam_vsync & vsync_q;  // blanking ends and the frame begins
    assign vsync_rise = cam_vsync & ~vsync_q;  // frame over

    ////////////////////////////////////////
    // idle / armed / capture FSM
    ////////////////////////////////////////

    always_ff @(posedge camera_clk)
    begin
        if (rst)
        begin
            state       <= SYNC_IDLE;
            start_q     <= 1'b1;  // no start edge straight out of reset
            vsync_q     <= 1'b1;
            busy        <= 1'b0;
            done        <= 1'b0;
            capture_en  <= 1'b0;
            frame_start <= 1'b0;
        end
        else
        begin
            start_q     <= start;
            vsync_q     <= cam_vsync;
            done        <= 1'b0;  // both strobes last one cycle
            frame_start <= 1'b0;
            case (state)
                SYNC_IDLE:
                begin
                    if (start_rise)
                    begin
                        state <= SYNC_ARMED;
                        busy  <= 1'b1;
                    end
                end
                SYNC_ARMED:
                begin
                    // start edges in here are ignored
                    if (vsync_fall)
                    begin
                        state       <= SYNC_CAPTURE;
                        capture_en  <= 1'b1;
                        frame_start <= 1'b1;
                    end
                end
                SYNC_CAPTURE:
                begin
                    if (vsync_rise)
                    begin
                        state      <= SYNC_IDLE;
                        capture_en <= 1'b0;
                        busy       <= 1'b0; // falls together with done
                        done       <= 1'b1;
                    end
                end
                default:
                begin
                    state      <= SYNC_IDLE;
                    busy       <= 1'b0;
                    capture_en <= 1'b0;
                end
            endcase
        end
    end

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////

    // done comes after capture has dropped and never during the frame
    a_done_outside_capture: assert property (@(posedge camera_clk) disable iff (rst)
        !(done && capture_en))
        else $error("done high while capture_en high");

endmodule

`default_nettype wire

// File: cam_byte_pair.sv
`timescale 1ns/100ps
`default_nettype none

`include "cam_capture_config.svh"

module cam_byte_pair
    import cam_capture_pkg::*;
(
    input  logic       camera_clk,
    input  logic       rst,
    input  logic       capture_en,  // level from frame sync
    input  logic       frame_start, // one cycle at capture begin
    input  logic       cam_href,
    input  byte_t      cam_data,
    output cam_pixel_s pix_out
);

    logic   phase;       // 0 expects high byte, 1 expects low byte
    byte_t  hi_byte;     // first byte of the pair
    logic   href_q;
    logic   line_used;   // this line gave at least one pixel
    coord_t hcount;
    coord_t vcount;

    logic      pix_valid_q;
    pixel565_t pix_data_q;
    coord_t    pix_h_q;
    coord_t    pix_v_q;

    logic byte_take;  // a byte is consumed this cycle
    logic pair_done;  // second byte of a pair
    logic href_fall;
    logic in_frame;

    assign byte_take = capture_en & cam_href & ~frame_start;
    assign pair_done = byte_take & phase;
    assign href_fall = href_q & ~cam_href; // end of line
    assign in_frame  = (hcount < `CAM_H_PIXELS) && (vcount < `CAM_V_LINES);

    ////////////////////////////////////////
    // phase and counters
    ////////////////////////////////////////

    always_ff @(posedge camera_clk)
    begin
        if (rst)
        begin
            phase       <= 1'b0;
            href_q      <= 1'b0;
            line_used   <= 1'b0;
            hcount      <= '0;
            vcount      <= '0;
            pix_valid_q <= 1'b0;
        end
        else
        begin
            href_q      <= cam_href;
            pix_valid_q <= pair_done & in_frame; // drop pixels off the frame
            if (frame_start)
            begin
                hcount    <= '0;
                vcount    <= '0;
                phase     <= 1'b0;
                line_used <= 1'b0;
            end
            else if (byte_take)
            begin
                phase <= ~phase;
                if (phase)
                begin
                    line_used <= 1'b1;
                    if (hcount != '1)       // hold at max, no wrap back into frame
                        hcount <= hcount + 1'b1;
                end
            end
            else if (href_fall)
            begin
                hcount    <= '0;
                phase     <= 1'b0;  // odd byte count loses its half pixel
                line_used <= 1'b0;
                if (line_used && (vcount != '1))
                    vcount <= vcount + 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // payload
    ////////////////////////////////////////

    always_ff @(posedge camera_clk)
    begin
        if (byte_take && !phase)
            hi_byte <= cam_data;
        if (pair_done)
        begin
            pix_data_q <= {hi_byte, cam_data}; // first byte is the high half
            pix_h_q    <= hcount;  // coords before the step
            pix_v_q    <= vcount;
        end
    end

    assign pix_out = '{valid: pix_valid_q, pix: pix_data_q, hcount: pix_h_q, vcount: pix_v_q};

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////

    a_valid_in_capture: assert property (@(posedge camera_clk) disable iff (rst)
        pix_valid_q |-> $past(capture_en))
        else $error("pixel valid outside capture");

    // two bytes per pixel so never back to back
    a_valid_spacing: assert property (@(posedge camera_clk) disable iff (rst)
        pix_valid_q |=> !pix_valid_q)
        else $error("pixel valid on consecutive cycles");

endmodule

`default_nettype wire

// File: cam_frame_store.sv
`timescale 1ns/100ps
`default_nettype none

`include "cam_capture_config.svh"

module cam_frame_store
    import cam_capture_pkg::*;
(
    input  logic       camera_clk,
    input  cam_pixel_s pix_in,   // write stream, no back-pressure
    input  addr_t      rd_addr,
    output rgb888_t    rd_pixel  // two cycles after rd_addr
);

    localparam int FRAME_PIXELS = `CAM_H_PIXELS * `CAM_V_LINES;
    localparam int LIN_W        = 2 * `CAM_COORD_W;  // full product width

    typedef logic [LIN_W-1:0] lin_t;

    pixel565_t mem [FRAME_PIXELS];

    lin_t      lin_addr;   // line * width + column before truncation
    logic      wr_en_q;
    addr_t     wr_addr_q;
    pixel565_t wr_data_q;
    pixel565_t rd_raw_q;   // first read stage
    rgb888_t   rd_exp;

    ////////////////////////////////////////
    // write port
    ////////////////////////////////////////

    assign lin_addr = lin_t'(pix_in.vcount) * lin_t'(`CAM_H_PIXELS) + lin_t'(pix_in.hcount);

    always_ff @(posedge camera_clk)
    begin
        wr_en_q   <= pix_in.valid;
        wr_addr_q <= addr_t'(lin_addr);
        wr_data_q <= pix_in.pix;
        if (wr_en_q)
            mem[wr_addr_q] <= wr_data_q;  // lands one cycle after valid
    end

    ////////////////////////////////////////
    // read port
    ////////////////////////////////////////

    // widen each field by repeating its lsb
    // so full scale 565 maps to full scale 888
    always_comb
    begin
        rd_exp = {rd_raw_q[15:11], {3{rd_raw_q[11]}},  // red 5 -> 8
                  rd_raw_q[10:5],  {2{rd_raw_q[5]}},   // green 6 -> 8
                  rd_raw_q[4:0],   {3{rd_raw_q[0]}}};  // blue 5 -> 8
    end

    always_ff @(posedge camera_clk)
    begin
        rd_raw_q <= mem[rd_addr];  // sees writes from earlier cycles only
        rd_pixel <= rd_exp;
    end

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////

    // pairing must filter coords so the store never aliases
    a_wr_in_frame: assert property (@(posedge camera_clk)
        pix_in.valid |-> (lin_addr < FRAME_PIXELS))
        else $error("write address %0d outside frame", lin_addr);

endmodule

`default_nettype wire

// File: cam_capture_top.sv
`timescale 1ns/100ps
`default_nettype none

module cam_capture_top
    import cam_capture_pkg::*;
(
    input  logic    camera_clk,  // sensor pixel clock
    input  logic    rst,
    input  logic    start,
    input  logic    cam_vsync,
    input  logic    cam_href,
    input  byte_t   cam_data,
    input  addr_t   rd_addr,
    output logic    busy,
    output logic    done,
    output rgb888_t rd_pixel
);

    logic       capture_en;
    logic       frame_start;
    cam_pixel_s pix_stream;  // pairing to store

    ////////////////////////////////////////
    // sync, pairing, store
    ////////////////////////////////////////

    cam_frame_sync u_frame_sync (
        .camera_clk  (camera_clk),
        .rst         (rst),
        .start       (start),
        .cam_vsync   (cam_vsync),
        .busy        (busy),
        .done        (done),
        .capture_en  (capture_en),
        .frame_start (frame_start)
    );

    cam_byte_pair u_byte_pair (
        .camera_clk  (camera_clk),
        .rst         (rst),
        .capture_en  (capture_en),
        .frame_start (frame_start),
        .cam_href    (cam_href),
        .cam_data    (cam_data),
        .pix_out     (pix_stream)
    );

    // readable three cycles after the second byte
    cam_frame_store u_frame_store (
        .camera_clk (camera_clk),
        .pix_in     (pix_stream),
        .rd_addr    (rd_addr),
        .rd_pixel   (rd_pixel)
    );

endmodule

`default_nettype wire

// File: tb_cam_capture.sv
`timescale 1ns/100ps
`default_nettype none

`include "cam_capture_config.svh"

module tb_cam_capture
    import cam_capture_pkg::*;
();

    localparam int CLK_NS       = 8;
    localparam int DRIVE_NS     = 1;    // input skew after the rising edge
    localparam int FRAME_PIXELS = `CAM_H_PIXELS * `CAM_V_LINES;
    localparam int BLANK_CYC    = 4;    // vsync high before and after a frame
    localparam int FRONT_CYC    = 3;    // vsync low before the first line
    localparam int GAP_CYC      = 4;    // href low between lines
    localparam int LINE_CYC     = 2 * `CAM_H_PIXELS + GAP_CYC;
    localparam int FRAME_CYC    = 2 * BLANK_CYC + FRONT_CYC + `CAM_V_LINES * LINE_CYC;
    localparam int READ_CYC     = 2 * FRAME_PIXELS + 2;
    localparam int N_FRAMES     = 4;
    localparam int N_READS      = 3;
    localparam int WAIT_CYC     = 16;   // limit on busy and done waits
    localparam int WATCHDOG_NS  =
        (N_FRAMES * FRAME_CYC + N_READS * READ_CYC + 6 * WAIT_CYC + 200) * CLK_NS;

    logic    camera_clk;
    logic    rst;
    logic    start;
    logic    cam_vsync;
    logic    cam_href;
    byte_t   cam_data;
    addr_t   rd_addr;
    logic    busy;
    logic    done;
    rgb888_t rd_pixel;

    logic [31:0] lfsr;                  // byte source
    pixel565_t   ref_mem [FRAME_PIXELS]; // expected store contents
    logic        frame_over;            // vsync back high so done may follow
    int          starts_issued;         // start edges that expect a done
    int          seq_errors;
    int          mon_errors = 0;
    int          done_count = 0;
    logic        busy_q;
    logic        done_q;

    ////////////////////////////////////////
    // clock and DUT
    ////////////////////////////////////////

    initial
    begin
        camera_clk = 1'b0;
        forever #(CLK_NS / 2) camera_clk = ~camera_clk;
    end

    cam_capture_top dut0 (
        .camera_clk (camera_clk),
        .rst        (rst),
        .start      (start),
        .cam_vsync  (cam_vsync),
        .cam_href   (cam_href),
        .cam_data   (cam_data),
        .rd_addr    (rd_addr),
        .busy       (busy),
        .done       (done),
        .rd_pixel   (rd_pixel)
    );

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    // 565 to 888 with each field padded by copies of its lsb
    function automatic rgb888_t expand565(input pixel565_t p);
        logic [4:0] r;
        logic [5:0] g;
        logic [4:0] b;
        r = p[15:11];
        g = p[10:5];
        b = p[4:0];
        return {r, {3{r[0]}}, g, {2{g[0]}}, b, {3{b[0]}}};
    endfunction

    task automatic next_byte(output byte_t b);
        for (int i = 0; i < 8; i++)
        begin
            lfsr = lfsr_next(lfsr);
            b    = {b[6:0], lfsr[0]};  // one step per bit
        end
    endtask

    task automatic show_error(input string msg);
        $display("Error at time %0t: %s", $time, msg);
    endtask

    // to the next drive point just after the rising edge
    task automatic step_cycle();
        @(posedge camera_clk);
        #DRIVE_NS;
    endtask

    ////////////////////////////////////////
    // sensor model
    ////////////////////////////////////////

    task automatic play_frame(input logic record);
        byte_t hi;
        byte_t lo;
        addr_t idx;
        cam_vsync = 1'b1;
        cam_href  = 1'b0;
        for (int i = 0; i < BLANK_CYC; i++)
        begin
            next_byte(cam_data);  // junk in blanking
            step_cycle();
        end
        cam_vsync  = 1'b0;
        frame_over = 1'b0;
        for (int i = 0; i < FRONT_CYC; i++)
        begin
            next_byte(cam_data);
            step_cycle();
        end
        for (int v = 0; v < `CAM_V_LINES; v++)
        begin
            cam_href = 1'b1;
            for (int h = 0; h < `CAM_H_PIXELS; h++)
            begin
                next_byte(hi);
                cam_data = hi;    // high half first
                step_cycle();
                next_byte(lo);
                cam_data = lo;
                step_cycle();
                idx = addr_t'(v * `CAM_H_PIXELS + h);
                if (record)
                    ref_mem[idx] = {hi, lo};
            end
            cam_href = 1'b0;
            for (int i = 0; i < GAP_CYC; i++)
            begin
                next_byte(cam_data);  // junk between lines
                step_cycle();
            end
        end
        cam_vsync  = 1'b1;
        frame_over = 1'b1;
        for (int i = 0; i < BLANK_CYC; i++)
        begin
            next_byte(cam_data);
            step_cycle();
        end
    endtask

    ////////////////////////////////////////
    // start, waits and readback
    ////////////////////////////////////////

    task automatic arm_capture();
        int n;
        n = 0;
        start = 1'b1;
        starts_issued++;
        step_cycle();
        while (!busy && n < WAIT_CYC)
        begin
            step_cycle();
            n++;
        end
        if (!busy)
        begin
            $display("busy did not rise within %0d cycles of the start edge", WAIT_CYC);
            seq_errors++;
        end
        start = 1'b0;
        step_cycle();
    endtask

    // stray start edge while busy is ignored
    task automatic pulse_start_late();
        repeat (40) step_cycle();
        start = 1'b1;
        step_cycle();
        start = 1'b0;
    endtask

    task automatic wait_done(input int target);
        int n;
        n = 0;
        while (done_count < target && n < WAIT_CYC)
        begin
            step_cycle();
            n++;
        end
        if (done_count < target)
        begin
            $display("done did not pulse within %0d cycles of the frame end", WAIT_CYC);
            seq_errors++;
        end
    endtask

    task automatic check_frame(input string tag);
        rgb888_t exp;
        for (int a = 0; a < FRAME_PIXELS; a++)
        begin
            rd_addr = addr_t'(a);
            step_cycle();
            step_cycle();             // two cycle read latency
            exp = expand565(ref_mem[rd_addr]);
            read_match: assert (rd_pixel === exp)
            else
            begin
                show_error($sformatf("%s, address %0d read %h, expected %h",
                                     tag, a, rd_pixel, exp));
                seq_errors++;
            end
        end
    endtask

    ////////////////////////////////////////
    // done / busy monitor
    ////////////////////////////////////////

    always @(negedge camera_clk)
    begin
        if (!rst)
        begin
            if (done)
            begin
                done_wanted: assert (starts_issued > done_count)
                else
                begin
                    show_error("done pulse with no start edge waiting");
                    mon_errors++;
                end
                done_late: assert (frame_over)
                else
                begin
                    show_error("done before the vsync rising edge");
                    mon_errors++;
                end
                done_busy: assert (!busy)
                else
                begin
                    show_error("busy still high with done");
                    mon_errors++;
                end
                done_short: assert (!done_q)
                else
                begin
                    show_error("done longer than one cycle");
                    mon_errors++;
                end
                done_count <= done_count + 1;
            end
            else if (starts_issued == done_count)
            begin
                idle_quiet: assert (!busy)
                else
                begin
                    show_error("busy high with no start edge");
                    mon_errors++;
                end
            end
            if (busy_q && !busy)
            begin
                busy_end: assert (done)
                else
                begin
                    show_error("busy fell without done");
                    mon_errors++;
                end
            end
        end
        busy_q <= rst ? 1'b0 : busy;
        done_q <= rst ? 1'b0 : done;
    end

    ////////////////////////////////////////
    // sequence
    ////////////////////////////////////////

    initial
    begin
        lfsr          = 32'h0c29_9345;
        seq_errors    = 0;
        starts_issued = 0;
        frame_over    = 1'b1;
        rst           = 1'b1;
        start         = 1'b0;
        cam_vsync     = 1'b1;
        cam_href      = 1'b0;
        cam_data      = '0;
        rd_addr       = '0;
        repeat (5) @(posedge camera_clk);
        #DRIVE_NS;
        rst = 1'b0;
        step_cycle();

        play_frame(1'b0);          // no start so it stays idle
        arm_capture();
        play_frame(1'b1);          // known data
        wait_done(1);
        check_frame("first capture");

        play_frame(1'b0);          // unarmed frame leaves the store untouched
        check_frame("after unarmed frame");

        arm_capture();
        fork
            play_frame(1'b1);
            pulse_start_late();
        join
        wait_done(2);
        repeat (WAIT_CYC) step_cycle();  // room for a wrong second done
        check_frame("second capture");

        done_total: assert (done_count == 2)
        else
        begin
            show_error($sformatf("saw %0d done pulses, expected 2", done_count));
            seq_errors++;
        end

        $display("errors: %0d (monitor %0d, sequence %0d)",
                 mon_errors + seq_errors, mon_errors, seq_errors);
        if (mon_errors + seq_errors == 0)
        begin
            $display("TESTBENCH PASSED");
        end
        else
        begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // hang guard
    initial
    begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, test sequence did not finish", WATCHDOG_NS);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
+incdir+.
cam_capture_pkg.sv
cam_frame_sync.sv
cam_byte_pair.sv
cam_frame_store.sv
cam_capture_top.sv
tb_cam_capture.sv

// File: Makefile
# Verilator build and run for the camera capture testbench
# override any variable on the command line, e.g. make run LOG=other.log

TOP       ?= tb_cam_capture
VERILATOR ?= verilator
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -j 0

SIM_BIN := $(OBJ_DIR)/V$(TOP)

SOURCES := cam_capture_config.svh \
           cam_capture_pkg.sv \
           cam_frame_sync.sv \
           cam_byte_pair.sv \
           cam_frame_store.sv \
           cam_capture_top.sv \
           tb_cam_capture.sv

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides pass or fail
run: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -qx "TESTBENCH PASSED" $(LOG); then \
		echo "run passed"; \
	else \
		echo "run failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
